// ==== include/bbc_mem_config.svh ====
`ifndef BBC_MEM_CONFIG_SVH
`define BBC_MEM_CONFIG_SVH

// store geometry, 256K bytes
`define BBC_STORE_AW 18

// region offsets inside the store
`define BBC_RAM_BASE 18'h00000
`define BBC_MOS_BASE 18'h0c000
`define BBC_SW_BASE  18'h20000

// sideways banks that accept writes
`define BBC_SWRAM_FIRST 3'd4
`define BBC_SWRAM_LAST  3'd7

`define BBC_UNMAPPED_BYTE 8'hff

// timing
`define BBC_INIT_CYCLES 16
`define BBC_INIT_CW     5
`define BBC_WAIT_CW     2
`define BBC_CPU_WAIT    3 // cycles in st_cpu_wait after the first
`define BBC_VID_WAIT    2 // same for st_vid_wait

`endif

// ==== hw/bbc_mem_pkg.sv ====
package bbc_mem_pkg;

   // where a cpu access lands
   typedef enum logic [2:0] {
      region_ram    = 3'd0,
      region_mos    = 3'd1,
      region_sw_rom = 3'd2,
      region_sw_ram = 3'd3,
      region_io     = 3'd4,
      region_none   = 3'd5
   } region_e;

   typedef enum logic [2:0] {
      st_init      = 3'd0,
      st_idle      = 3'd1,
      st_cpu       = 3'd2,
      st_cpu_wait  = 3'd3,
      st_vid       = 3'd4,
      st_vid_wait  = 3'd5,
      st_load      = 3'd6,
      st_load_done = 3'd7
   } seq_state_e;

endpackage

// ==== hw/addr_map.sv ====
`timescale 1ns/1ps
`include "bbc_mem_config.svh"

module addr_map (
   input  logic [15:0]                mem_adr,
   input  logic [3:0]                 mem_romsel,
   output bbc_mem_pkg::region_e       region,
   output logic [`BBC_STORE_AW-1:0]   store_adr,
   output logic                       wr_allow
);

   logic [2:0] bank; // only banks 0..7 exist
   logic       is_io;

   assign bank  = mem_romsel[2:0];
   assign is_io = (mem_adr[15:8] == 8'hfc) || (mem_adr[15:8] == 8'hfd) ||
                  (mem_adr[15:8] == 8'hfe);

   always_comb begin
      region    = bbc_mem_pkg::region_none;
      store_adr = '0;
      if (!mem_adr[15]) begin // 0000-7fff
         region    = bbc_mem_pkg::region_ram;
         store_adr = `BBC_RAM_BASE + {3'b000, mem_adr[14:0]};
      end else if (mem_adr[15:14] == 2'b10) begin
         // sideways window, select 8..15 left unmapped
         if (!mem_romsel[3]) begin
            store_adr = `BBC_SW_BASE + {1'b0, bank, mem_adr[13:0]};
            if (bank >= `BBC_SWRAM_FIRST && bank <= `BBC_SWRAM_LAST)
               region = bbc_mem_pkg::region_sw_ram;
            else
               region = bbc_mem_pkg::region_sw_rom;
         end
      end else if (is_io) begin
         region = bbc_mem_pkg::region_io; // fred, jim, sheila
      end else begin
         region    = bbc_mem_pkg::region_mos;
         store_adr = `BBC_MOS_BASE + {4'b0000, mem_adr[13:0]};
      end
   end

   assign wr_allow = (region == bbc_mem_pkg::region_ram) ||
                     (region == bbc_mem_pkg::region_sw_ram);

endmodule

// ==== hw/mem_sequencer.sv ====
`timescale 1ns/1ps
`include "bbc_mem_config.svh"

module mem_sequencer (
   input  logic                       clk_32m,
   input  logic                       rst_n,
   input  logic                       mem_sync,
   input  logic                       mem_we,
   input  logic [7:0]                 mem_do,
   input  logic [14:0]                vid_adr,
   input  bbc_mem_pkg::region_e       region,
   input  logic [`BBC_STORE_AW-1:0]   store_adr,
   input  logic                       wr_allow,
   input  logic                       load_active,
   input  logic                       wr_pend,
   input  logic [`BBC_STORE_AW-1:0]   load_adr,
   input  logic [7:0]                 load_byte,
   input  logic                       pll_ready,
   input  logic                       user_reset,
   output logic [`BBC_STORE_AW-1:0]   st_adr,
   output logic                       st_we,
   output logic [7:0]                 st_wdata,
   output logic                       wr_done,
   output bbc_mem_pkg::seq_state_e    state,
   output logic                       rd_take,
   output bbc_mem_pkg::region_e       rd_region,
   output logic                       mem_ready,
   output logic                       core_reset
);

   logic [`BBC_INIT_CW-1:0] init_cnt;
   logic [`BBC_WAIT_CW-1:0] wait_cnt;
   logic                    cpu_we_q; // latched direction of the cpu access
   logic                    reset_in;

   assign reset_in = !pll_ready || !mem_ready || user_reset || load_active;

   // writes leave mem_di alone
   assign rd_take = (wait_cnt == '0) &&
                    (((state == bbc_mem_pkg::st_cpu_wait) && !cpu_we_q) ||
                     (state == bbc_mem_pkg::st_vid_wait));

   // store ready after a fixed count
   always_ff @(posedge clk_32m or negedge rst_n) begin
      if (!rst_n) begin
         init_cnt  <= '0;
         mem_ready <= 1'b0;
      end else if (!mem_ready) begin
         init_cnt  <= init_cnt + 1'b1;
         mem_ready <= (init_cnt == `BBC_INIT_CW'(`BBC_INIT_CYCLES - 1));
      end
   end

   // core reset follows the cpu bus cycle and a load forces it at once
   always_ff @(posedge clk_32m or negedge rst_n) begin
      if (!rst_n)
         core_reset <= 1'b1;
      else if (load_active)
         core_reset <= 1'b1;
      else if (mem_sync)
         core_reset <= reset_in;
   end

   always_ff @(posedge clk_32m or negedge rst_n) begin
      if (!rst_n) begin
         state    <= bbc_mem_pkg::st_init;
         st_we    <= 1'b0;
         wr_done  <= 1'b0;
         wait_cnt <= '0;
         cpu_we_q <= 1'b0;
      end else begin
         st_we   <= 1'b0; // single cycle strobes
         wr_done <= 1'b0;
         case (state)
            bbc_mem_pkg::st_init: begin
               if (mem_ready)
                  state <= bbc_mem_pkg::st_idle;
            end
            bbc_mem_pkg::st_idle: begin
               if (load_active) begin // strobes ignored during a load
                  if (wr_pend) begin
                     st_we <= 1'b1;
                     state <= bbc_mem_pkg::st_load;
                  end
               end else if (mem_sync) begin
                  st_we    <= mem_we && wr_allow;
                  cpu_we_q <= mem_we;
                  state    <= bbc_mem_pkg::st_cpu;
               end
            end
            bbc_mem_pkg::st_cpu: begin
               wait_cnt <= `BBC_WAIT_CW'(`BBC_CPU_WAIT);
               state    <= bbc_mem_pkg::st_cpu_wait;
            end
            bbc_mem_pkg::st_cpu_wait: begin
               if (wait_cnt == '0)
                  state <= bbc_mem_pkg::st_vid;
               else
                  wait_cnt <= wait_cnt - 1'b1;
            end
            bbc_mem_pkg::st_vid: begin
               wait_cnt <= `BBC_WAIT_CW'(`BBC_VID_WAIT);
               state    <= bbc_mem_pkg::st_vid_wait;
            end
            bbc_mem_pkg::st_vid_wait: begin
               if (wait_cnt == '0)
                  state <= bbc_mem_pkg::st_idle;
               else
                  wait_cnt <= wait_cnt - 1'b1;
            end
            bbc_mem_pkg::st_load: begin
               wr_done <= 1'b1; // byte is in the store now
               state   <= bbc_mem_pkg::st_load_done;
            end
            default: state <= bbc_mem_pkg::st_idle; // st_load_done
         endcase
      end
   end

   // store address and data plus the region for the capture side
   always_ff @(posedge clk_32m) begin
      if (state == bbc_mem_pkg::st_idle) begin
         if (load_active) begin
            st_adr   <= load_adr;
            st_wdata <= load_byte;
         end else if (mem_sync) begin
            st_adr    <= store_adr;
            st_wdata  <= mem_do;
            rd_region <= region;
         end
      end else if ((state == bbc_mem_pkg::st_cpu_wait) && (wait_cnt == '0)) begin
         st_adr    <= `BBC_RAM_BASE + {3'b000, vid_adr}; // video fetch next
         rd_region <= bbc_mem_pkg::region_ram;
      end
   end

   // the core must space its strobes past a full cpu + video slot
   a_sync_spacing: assert property (@(posedge clk_32m) disable iff (!rst_n)
      mem_sync |-> !(state inside {bbc_mem_pkg::st_cpu, bbc_mem_pkg::st_cpu_wait,
                                   bbc_mem_pkg::st_vid, bbc_mem_pkg::st_vid_wait}));

   // a cpu write may only land in ram or sideways ram
   a_we_allowed: assert property (@(posedge clk_32m) disable iff (!rst_n)
      st_we |-> (state == bbc_mem_pkg::st_load) ||
                ((state == bbc_mem_pkg::st_cpu) &&
                 (rd_region inside {bbc_mem_pkg::region_ram,
                                    bbc_mem_pkg::region_sw_ram})));

endmodule

// ==== hw/byte_store.sv ====
`timescale 1ns/1ps
`include "bbc_mem_config.svh"

module byte_store (
   input  logic                       clk_32m,
   input  logic [`BBC_STORE_AW-1:0]   st_adr,
   input  logic                       st_we,
   input  logic [7:0]                 st_wdata,
   output logic [7:0]                 st_rdata
);

   logic [7:0]               mem [0:(1 << `BBC_STORE_AW)-1];
   logic [`BBC_STORE_AW-1:0] adr_q; // column address stage
   logic [7:0]               rdata_q;

   always_ff @(posedge clk_32m) begin
      if (st_we)
         mem[st_adr] <= st_wdata; // lands in the addressed cycle
      adr_q   <= st_adr;
      rdata_q <= mem[adr_q];      // second stage, data out
   end

   assign st_rdata = rdata_q;

   // an X on the write path would corrupt a random location
   a_no_x_write: assert property (@(posedge clk_32m)
      st_we |-> !$isunknown({st_adr, st_wdata}));

endmodule

// ==== hw/load_port.sv ====
`timescale 1ns/1ps
`include "bbc_mem_config.svh"

module load_port (
   input  logic                       clk_32m,
   input  logic                       rst_n,
   input  logic                       load_active,
   input  logic [`BBC_STORE_AW-1:0]   load_base,
   input  logic                       load_req,
   input  logic [7:0]                 load_data,
   output logic                       load_ack,
   output logic                       wr_pend,
   output logic [`BBC_STORE_AW-1:0]   load_adr,
   output logic [7:0]                 load_byte,
   input  logic                       wr_done
);

   logic active_q;
   logic new_req;

   // req only counts once the previous ack has gone
   assign new_req = load_active && load_req && !load_ack && !wr_pend;

   always_ff @(posedge clk_32m or negedge rst_n) begin
      if (!rst_n) begin
         active_q <= 1'b0;
         wr_pend  <= 1'b0;
         load_ack <= 1'b0;
      end else begin
         active_q <= load_active;
         if (wr_done) begin
            wr_pend  <= 1'b0;
            load_ack <= 1'b1;
         end else if (new_req) begin
            wr_pend <= 1'b1;
         end else if (load_ack && !load_req) begin
            load_ack <= 1'b0; // host has seen it
         end
      end
   end

   always_ff @(posedge clk_32m) begin
      if (load_active && !active_q)
         load_adr <= load_base; // start of a new image
      else if (wr_done)
         load_adr <= load_adr + 1'b1;
      if (new_req)
         load_byte <= load_data;
   end

   // host keeps req up until the byte is acknowledged
   a_req_held: assert property (@(posedge clk_32m) disable iff (!rst_n)
      (wr_pend && !load_ack) |-> load_req);

endmodule

// ==== hw/read_capture.sv ====
`timescale 1ns/1ps
`include "bbc_mem_config.svh"

module read_capture (
   input  logic                       clk_32m,
   input  logic                       rst_n,
   input  logic                       rd_take,
   input  bbc_mem_pkg::region_e       rd_region,
   input  bbc_mem_pkg::seq_state_e    state,
   input  logic [7:0]                 st_rdata,
   output logic [7:0]                 mem_di,
   output logic [7:0]                 vid_data
);

   logic       unmapped;
   logic [7:0] rd_byte;

   // io has no backing in the store
   assign unmapped = (rd_region == bbc_mem_pkg::region_io) ||
                     (rd_region == bbc_mem_pkg::region_none);
   assign rd_byte  = unmapped ? `BBC_UNMAPPED_BYTE : st_rdata;

   always_ff @(posedge clk_32m or negedge rst_n) begin
      if (!rst_n) begin
         mem_di   <= `BBC_UNMAPPED_BYTE;
         vid_data <= 8'h00;
      end else if (rd_take) begin
         if (state == bbc_mem_pkg::st_cpu_wait)
            mem_di <= rd_byte;   // held until the next cpu read
         else if (state == bbc_mem_pkg::st_vid_wait)
            vid_data <= rd_byte;
      end
   end

endmodule

// ==== hw/bbc_mem_top.sv ====
`timescale 1ns/1ps
`include "bbc_mem_config.svh"

module bbc_mem_top (
   input  logic                       clk_32m,
   input  logic                       rst_n,
   input  logic                       pll_ready,
   input  logic                       user_reset,
   input  logic                       mem_sync,
   input  logic [15:0]                mem_adr,
   input  logic [3:0]                 mem_romsel,
   input  logic                       mem_we,
   input  logic [7:0]                 mem_do,
   output logic [7:0]                 mem_di,
   input  logic [14:0]                vid_adr,
   output logic [7:0]                 vid_data,
   input  logic                       load_active,
   input  logic [`BBC_STORE_AW-1:0]   load_base,
   input  logic                       load_req,
   output logic                       load_ack,
   input  logic [7:0]                 load_data,
   output logic                       mem_ready,
   output logic                       core_reset
);

   bbc_mem_pkg::region_e      region;
   bbc_mem_pkg::region_e      rd_region;
   bbc_mem_pkg::seq_state_e   state;
   logic [`BBC_STORE_AW-1:0]  store_adr;
   logic                      wr_allow;
   logic                      wr_pend;
   logic                      wr_done;
   logic [`BBC_STORE_AW-1:0]  load_adr;
   logic [7:0]                load_byte;
   logic [`BBC_STORE_AW-1:0]  st_adr;
   logic                      st_we;
   logic [7:0]                st_wdata;
   logic [7:0]                st_rdata;
   logic                      rd_take;

   addr_map i_addr_map (
      .mem_adr    (mem_adr),
      .mem_romsel (mem_romsel),
      .region     (region),
      .store_adr  (store_adr),
      .wr_allow   (wr_allow)
   );

   mem_sequencer i_mem_sequencer (
      .clk_32m     (clk_32m),
      .rst_n       (rst_n),
      .mem_sync    (mem_sync),
      .mem_we      (mem_we),
      .mem_do      (mem_do),
      .vid_adr     (vid_adr),
      .region      (region),
      .store_adr   (store_adr),
      .wr_allow    (wr_allow),
      .load_active (load_active),
      .wr_pend     (wr_pend),
      .load_adr    (load_adr),
      .load_byte   (load_byte),
      .pll_ready   (pll_ready),
      .user_reset  (user_reset),
      .st_adr      (st_adr),
      .st_we       (st_we),
      .st_wdata    (st_wdata),
      .wr_done     (wr_done),
      .state       (state),
      .rd_take     (rd_take),
      .rd_region   (rd_region),
      .mem_ready   (mem_ready),
      .core_reset  (core_reset)
   );

   // stands in for the sdram
   byte_store i_byte_store (
      .clk_32m  (clk_32m),
      .st_adr   (st_adr),
      .st_we    (st_we),
      .st_wdata (st_wdata),
      .st_rdata (st_rdata)
   );

   load_port i_load_port (
      .clk_32m     (clk_32m),
      .rst_n       (rst_n),
      .load_active (load_active),
      .load_base   (load_base),
      .load_req    (load_req),
      .load_data   (load_data),
      .load_ack    (load_ack),
      .wr_pend     (wr_pend),
      .load_adr    (load_adr),
      .load_byte   (load_byte),
      .wr_done     (wr_done)
   );

   read_capture i_read_capture (
      .clk_32m   (clk_32m),
      .rst_n     (rst_n),
      .rd_take   (rd_take),
      .rd_region (rd_region),
      .state     (state),
      .st_rdata  (st_rdata),
      .mem_di    (mem_di),
      .vid_data  (vid_data)
   );

endmodule

// ==== test/tb_bbc_mem.sv ====
`timescale 1ns/1ps
`include "bbc_mem_config.svh"

module tb_bbc_mem;

   typedef enum logic [1:0] {op_load, op_write, op_read} op_e;

   typedef struct packed {
      op_e         op;
      logic [3:0]  sel;
      logic [15:0] adr;
      logic [7:0]  dat;
      logic [14:0] vad;      // ram byte fetched by video after the access
      logic [7:0]  exp_di;
      logic [7:0]  exp_vid;
   } row_t;

   localparam int ack_timeout  = 50;
   localparam int init_timeout = 40;

   logic                     clk_32m;
   logic                     rst_n;
   logic                     pll_ready;
   logic                     user_reset;
   logic                     mem_sync;
   logic [15:0]              mem_adr;
   logic [3:0]               mem_romsel;
   logic                     mem_we;
   logic [7:0]               mem_do;
   logic [7:0]               mem_di;
   logic [14:0]              vid_adr;
   logic [7:0]               vid_data;
   logic                     load_active;
   logic [`BBC_STORE_AW-1:0] load_base;
   logic                     load_req;
   logic                     load_ack;
   logic [7:0]               load_data;
   logic                     mem_ready;
   logic                     core_reset;

   row_t       rows [$];
   logic [7:0] model_mem [int]; // expected store contents
   int         seed;
   int         errors;
   int         tests;
   int         tests_failed;

   bbc_mem_top i_dut (
      .clk_32m     (clk_32m),
      .rst_n       (rst_n),
      .pll_ready   (pll_ready),
      .user_reset  (user_reset),
      .mem_sync    (mem_sync),
      .mem_adr     (mem_adr),
      .mem_romsel  (mem_romsel),
      .mem_we      (mem_we),
      .mem_do      (mem_do),
      .mem_di      (mem_di),
      .vid_adr     (vid_adr),
      .vid_data    (vid_data),
      .load_active (load_active),
      .load_base   (load_base),
      .load_req    (load_req),
      .load_ack    (load_ack),
      .load_data   (load_data),
      .mem_ready   (mem_ready),
      .core_reset  (core_reset)
   );

   initial begin
      clk_32m = 1'b0;
      forever #10 clk_32m = ~clk_32m;
   end

   // store offset of a cpu address or -1 when unmapped
   function automatic int map_adr(input logic [3:0] sel, input logic [15:0] adr);
      if (adr < 16'h8000)
         return int'(adr);
      if (adr < 16'hc000)
         return (sel > 4'd7) ? -1 : 32'h20000 + int'(sel) * 32'h4000 + int'(adr) - 32'h8000;
      if (adr >= 16'hfc00 && adr < 16'hff00)
         return -1; // fred, jim, sheila
      return 32'h0c000 + int'(adr) - 32'hc000;
   endfunction

   function automatic bit writable(input logic [3:0] sel, input logic [15:0] adr);
      return (adr < 16'h8000) || (adr < 16'hc000 && sel >= 4'd4 && sel <= 4'd7);
   endfunction

   function automatic string op_text(input op_e op);
      case (op)
         op_load:  return "load";
         op_write: return "write";
         default:  return "read";
      endcase
   endfunction

   task automatic add_row(input op_e op, input logic [3:0] sel, input logic [15:0] adr,
                          input logic [14:0] vad);
      row_t r;
      r.op      = op;
      r.sel     = sel;
      r.adr     = adr;
      r.dat     = 8'($random(seed));
      r.vad     = vad;
      r.exp_di  = 8'h00;
      r.exp_vid = 8'h00;
      rows.push_back(r);
   endtask

   task automatic build_table();
      int i;
      for (i = 0; i < 4; i++)
         add_row(op_load, 4'd0, 16'hc010 + 16'(i), 15'h0000); // mos image
      for (i = 0; i < 4; i++)
         add_row(op_load, 4'd2, 16'h8100 + 16'(i), 15'h0000); // bank 2 rom
      for (i = 0; i < 4; i++)
         add_row(op_load, 4'd0, 16'h1200 + 16'(i), 15'h0000);
      add_row(op_load, 4'd4, 16'h8200, 15'h0000);
      add_row(op_load, 4'd1, 16'h8300, 15'h0000);
      add_row(op_load, 4'd0, 16'h0000, 15'h0000);
      // readback with video walking the loaded ram
      for (i = 0; i < 4; i++) begin
         add_row(op_read, 4'd3, 16'hc010 + 16'(i), 15'h1200 + 15'(i));
         add_row(op_read, 4'd2, 16'h8100 + 16'(i), 15'h1203 - 15'(i));
         add_row(op_read, 4'd0, 16'h1200 + 16'(i), 15'h1200 + 15'(i));
      end
      add_row(op_write, 4'd0, 16'h1201, 15'h1201); // video sees the new byte
      add_row(op_read,  4'd0, 16'h1201, 15'h1200);
      add_row(op_write, 4'd5, 16'h8200, 15'h1201);
      add_row(op_read,  4'd5, 16'h8200, 15'h1202);
      add_row(op_read,  4'd4, 16'h8200, 15'h1203);
      // dropped writes
      add_row(op_write, 4'd0, 16'hc011, 15'h1200);
      add_row(op_read,  4'd0, 16'hc011, 15'h1201);
      add_row(op_write, 4'd1, 16'h8300, 15'h1202);
      add_row(op_read,  4'd1, 16'h8300, 15'h1203);
      add_row(op_write, 4'd0, 16'hfe40, 15'h1200);
      add_row(op_read,  4'd0, 16'h0000, 15'h0000);
      // unmapped reads between mapped ones so that mem_di has to change
      add_row(op_read, 4'd0, 16'hfc00, 15'h1200);
      add_row(op_read, 4'd0, 16'h1200, 15'h1201);
      add_row(op_read, 4'd6, 16'hfd7f, 15'h1202);
      add_row(op_read, 4'd2, 16'h8101, 15'h1203);
      add_row(op_read, 4'd0, 16'hfeff, 15'h1200);
      add_row(op_read, 4'd3, 16'hc012, 15'h1201);
      add_row(op_read, 4'd10, 16'h8100, 15'h1202); // low bits would pick bank 2
      add_row(op_read, 4'd0, 16'h1203, 15'h1203);
      add_row(op_read, 4'd15, 16'hbfff, 15'h0000);
   endtask

   task automatic fill_expected();
      int a;
      foreach (rows[i]) begin
         a = map_adr(rows[i].sel, rows[i].adr);
         if (rows[i].op == op_load) begin
            model_mem[a] = rows[i].dat;
         end else begin
            if (rows[i].op == op_write && writable(rows[i].sel, rows[i].adr))
               model_mem[a] = rows[i].dat;
            rows[i].exp_di  = (a < 0) ? `BBC_UNMAPPED_BYTE : model_mem[a];
            rows[i].exp_vid = model_mem[int'(rows[i].vad)]; // ram base is 0
         end
      end
   endtask

   task automatic compare_byte(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0d ns: %s = %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("%s: pass", name);
      end else begin
         tests_failed++;
         $display("%s: fail", name);
      end
   endtask

   task automatic wait_ack(input logic level);
      int n;
      n = 0;
      @(negedge clk_32m);
      while (load_ack !== level && n < ack_timeout) begin
         @(negedge clk_32m);
         n++;
      end
      if (load_ack !== level) begin
         $display("timeout at %0d ns: load_ack did not go to %b within %0d cycles",
                  $time, level, ack_timeout);
         errors++;
      end
   endtask

   task automatic start_load(input logic [`BBC_STORE_AW-1:0] base);
      @(posedge clk_32m);
      load_active <= 1'b1;
      load_base   <= base;
   endtask

   task automatic end_load();
      @(posedge clk_32m);
      load_active <= 1'b0;
   endtask

   task automatic send_byte(input logic [7:0] dat);
      @(posedge clk_32m);
      load_data <= dat;
      load_req  <= 1'b1;
      wait_ack(1'b1);
      @(posedge clk_32m);
      load_req <= 1'b0;
      wait_ack(1'b0); // ack must drop before the next byte
   endtask

   // mem_di settles 6 cycles after the strobe and vid_data 10
   task automatic bus_cycle(input logic [3:0] sel, input logic [15:0] adr, input logic we,
                            input logic [7:0] dat, input logic [14:0] vad,
                            output logic [7:0] di, output logic [7:0] vd);
      int n;
      @(posedge clk_32m);
      mem_romsel <= sel;
      mem_adr    <= adr;
      mem_we     <= we;
      mem_do     <= dat;
      vid_adr    <= vad;
      mem_sync   <= 1'b1;
      @(posedge clk_32m);
      mem_sync <= 1'b0;
      for (n = 1; n <= 9; n++) begin
         @(posedge clk_32m);
         @(negedge clk_32m);
         if (n == 5)
            di = mem_di;
      end
      vd = vid_data;
      repeat (2) @(posedge clk_32m); // keeps strobes 12+ cycles apart
   endtask

   initial begin
      int         n;
      int         errs0;
      int         sa;
      int         last_sa;
      bit         loading;
      logic [7:0] got_di;
      logic [7:0] got_vid;

      seed         = 32'h6ed3;
      errors       = 0;
      tests        = 0;
      tests_failed = 0;
      last_sa      = 0;
      loading      = 1'b0;
      rst_n        = 1'b0;
      pll_ready    = 1'b0;
      user_reset   = 1'b0;
      mem_sync     = 1'b0;
      mem_adr      = 16'h0000;
      mem_romsel   = 4'd0;
      mem_we       = 1'b0;
      mem_do       = 8'h00;
      vid_adr      = 15'h0000;
      load_active  = 1'b0;
      load_base    = '0;
      load_req     = 1'b0;
      load_data    = 8'h00;
      build_table();
      fill_expected();

      repeat (10) @(posedge clk_32m);
      rst_n <= 1'b1;

      errs0 = errors;
      @(negedge clk_32m);
      compare_bit("core_reset", core_reset, 1'b1);
      compare_bit("mem_ready", mem_ready, 1'b0);
      finish_test("reset state", errs0);

      errs0 = errors;
      n = 0;
      while (!mem_ready && n < init_timeout) begin
         @(posedge clk_32m);
         n++;
         @(negedge clk_32m);
      end
      if (!mem_ready) begin
         $display("timeout at %0d ns: mem_ready still low after %0d cycles", $time, n);
         errors++;
      end else if (n != `BBC_INIT_CYCLES) begin
         $display("CHECK FAILED at %0d ns: mem_ready rise cycle = %0d, expected %0d",
                  $time, n, `BBC_INIT_CYCLES);
         errors++;
      end
      finish_test("store ready count", errs0);

      errs0 = errors;
      bus_cycle(4'd0, 16'h0000, 1'b0, 8'h00, 15'h0000, got_di, got_vid);
      compare_bit("core_reset", core_reset, 1'b1); // pll still unlocked
      finish_test("core reset without pll lock", errs0);

      errs0 = errors;
      @(posedge clk_32m);
      pll_ready <= 1'b1;
      @(negedge clk_32m);
      compare_bit("core_reset", core_reset, 1'b1); // waits for the strobe
      bus_cycle(4'd0, 16'h0000, 1'b0, 8'h00, 15'h0000, got_di, got_vid);
      compare_bit("core_reset", core_reset, 1'b0);
      finish_test("core reset release at strobe", errs0);

      errs0 = errors;
      @(posedge clk_32m);
      user_reset <= 1'b1;
      bus_cycle(4'd0, 16'h0000, 1'b0, 8'h00, 15'h0000, got_di, got_vid);
      compare_bit("core_reset", core_reset, 1'b1);
      @(posedge clk_32m);
      user_reset <= 1'b0;
      bus_cycle(4'd0, 16'h0000, 1'b0, 8'h00, 15'h0000, got_di, got_vid);
      compare_bit("core_reset", core_reset, 1'b0);
      finish_test("core reset from user reset", errs0);

      errs0 = errors;
      @(posedge clk_32m);
      load_active <= 1'b1;
      @(posedge clk_32m);
      @(negedge clk_32m);
      compare_bit("core_reset", core_reset, 1'b1); // no strobe needed
      @(posedge clk_32m);
      load_active <= 1'b0;
      finish_test("core reset forced by loader", errs0);

      foreach (rows[i]) begin
         errs0 = errors;
         if (rows[i].op == op_load) begin
            sa = map_adr(rows[i].sel, rows[i].adr);
            if (loading && sa != last_sa + 1) begin
               end_load();
               loading = 1'b0;
            end
            if (!loading) begin
               start_load(`BBC_STORE_AW'(sa));
               loading = 1'b1;
            end
            send_byte(rows[i].dat);
            last_sa = sa;
            if (i + 1 == rows.size() || rows[i + 1].op != op_load) begin
               end_load();
               loading = 1'b0;
            end
         end else begin
            bus_cycle(rows[i].sel, rows[i].adr, rows[i].op == op_write, rows[i].dat,
                      rows[i].vad, got_di, got_vid);
            if (rows[i].op == op_read)
               compare_byte("mem_di", got_di, rows[i].exp_di);
            compare_byte("vid_data", got_vid, rows[i].exp_vid);
         end
         finish_test($sformatf("row %0d %s sel %0d adr %h", i, op_text(rows[i].op),
                               rows[i].sel, rows[i].adr), errs0);
      end

      $display("%0d tests, %0d passed, %0d failed, %0d errors", tests,
               tests - tests_failed, tests_failed, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+include
hw/bbc_mem_pkg.sv
hw/addr_map.sv
hw/mem_sequencer.sv
hw/byte_store.sv
hw/load_port.sv
hw/read_capture.sv
hw/bbc_mem_top.sv
test/tb_bbc_mem.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert -Wno-fatal
TOP       := tb_bbc_mem
FILELIST  := verilog.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard hw/*.sv include/*.svh test/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
